//--- all.f
verilog/video_pkg.sv
verilog/board_pkg.sv
verilog/reset_gen.sv
verilog/vga_timing.sv
verilog/pattern_gen.sv
verilog/led_status.sv
verilog/board_top.sv
dv/tb_board_top.sv

//--- dv/tb_board_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_board_top;

  import video_pkg::*;
  import board_pkg::*;

  localparam int ht              = int'(h_total);
  localparam int frame_len       = ht * int'(v_total);
  localparam int hs_first        = int'(h_active) + int'(h_front) + 1; // pins lag by one
  localparam int vs_first        = (int'(v_active) + int'(v_front)) * ht + 1;
  localparam int watchdog_cycles = 3 * frame_len + 1000;
  localparam int num_presses     = 20;

  logic                 design_clk;
  logic                 rst_n;
  logic [num_btns-1:0]  btns;
  logic [num_leds-1:0]  leds;
  logic [pin_depth-1:0] r;
  logic [pin_depth-1:0] g;
  logic [pin_depth-1:0] b;
  logic                 hs;
  logic                 vs;

  logic                   checks_on;
  int                     stretch;
  logic                   core_on;
  logic                   pin_on;
  int                     cyc;        // cycles since core release
  logic [coord_w-1:0]     cx;
  logic [coord_w-1:0]     cy;
  logic [coord_w-1:0]     px;         // position shown on the pins
  logic [coord_w-1:0]     py;
  logic [color_depth-1:0] fcnt;
  logic [color_depth-1:0] pf;
  logic                   fs_d;
  logic                   hb_exp;
  logic                   hs_prev;
  logic                   vs_prev;
  int                     hs_run = 0;
  int                     vs_run = 0;
  int                     hs_falls = 0;
  int                     vs_falls = 0;
  int                     errors = 0;
  int                     tests = 0;
  int                     tests_failed = 0;
  logic [15:0]            lfsr;
  logic [num_btns-1:0]    exp_tgl;

  logic                 pix_act;
  logic [pin_depth-1:0] exp_r;
  logic [pin_depth-1:0] exp_g;
  logic [pin_depth-1:0] exp_b;
  logic                 exp_hs;
  logic                 exp_vs;

  board_top i_dut (
    .design_clk (design_clk),
    .rst_n      (rst_n),
    .btns       (btns),
    .leds       (leds),
    .r          (r),
    .g          (g),
    .b          (b),
    .hs         (hs),
    .vs         (vs)
  );

  initial begin
    design_clk = 1'b0;
    forever #20 design_clk = ~design_clk;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hb400;
    end
    return n;
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    errors++;
    $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
  endtask

  task automatic report_text(input string msg);
    errors++;
    $display("%s at %0t", msg, $time);
  endtask

  task automatic finish_test(input string name, input int start_errs);
    tests++;
    if (errors != start_errs) begin
      tests_failed++;
    end
    $display("test %s: %s, %0d errors", name, (errors == start_errs) ? "ok" : "FAILED",
             errors - start_errs);
  endtask

  // one press of a random button set, then release
  task automatic press_buttons();
    int mask;
    int hold;
    int gap;
    take_bits(3, mask);
    take_bits(3, hold);
    take_bits(3, gap);
    if (mask == 0) begin
      mask = 1;
    end
    btns = mask[num_btns-1:0];
    repeat (3) @(posedge design_clk);
    @(negedge design_clk);
    assert (leds[num_btns] === 1'b1)
      else report_value("leds[3]", 32'(leds[num_btns]), 32'h1);
    repeat (hold + 1) @(negedge design_clk);
    btns = '0;
    exp_tgl = exp_tgl ^ mask[num_btns-1:0];
    repeat (gap + 4) @(negedge design_clk);
    assert (leds[num_btns-1:0] === exp_tgl)
      else report_value("leds[2:0]", 32'(leds[num_btns-1:0]), 32'(exp_tgl));
    assert (leds[num_btns] === 1'b0)
      else report_value("leds[3]", 32'(leds[num_btns]), 32'h0);
  endtask

  // reference counters started from the computed release cycle
  always @(posedge design_clk) begin
    if (!rst_n) begin
      stretch <= 0;
      core_on <= 1'b0;
      pin_on  <= 1'b0;
      fs_d    <= 1'b0;
      hb_exp  <= 1'b0;
    end else if (!core_on) begin
      if (stretch == reset_stretch) begin
        core_on <= 1'b1;
        cyc     <= 0;
        cx      <= '0;
        cy      <= '0;
        fcnt    <= '0;
      end else begin
        stretch <= stretch + 1;
      end
    end else begin
      pin_on <= 1'b1;
      px     <= cx;
      py     <= cy;
      pf     <= fcnt;
      cyc    <= cyc + 1;
      fs_d   <= (cx == '0) && (cy == '0);
      hb_exp <= hb_exp ^ fs_d;
      if ((cx == '0) && (cy == '0)) begin
        fcnt <= fcnt + 6'd1;
      end
      if (cx == h_total - 10'd1) begin
        cx <= '0;
        cy <= (cy == v_total - 10'd1) ? '0 : cy + 10'd1;
      end else begin
        cx <= cx + 10'd1;
      end
    end
  end

  always @(posedge design_clk) begin
    hs_prev <= hs;
    vs_prev <= vs;
    hs_run  <= (hs === 1'b0) ? hs_run + 1 : 0;
    vs_run  <= (vs === 1'b0) ? vs_run + 1 : 0;
    if (checks_on && hs_prev === 1'b1 && hs === 1'b0) begin
      hs_falls <= hs_falls + 1;
    end
    if (checks_on && vs_prev === 1'b1 && vs === 1'b0) begin
      vs_falls <= vs_falls + 1;
    end
  end

  always_comb begin
    pix_act = pin_on && (px < h_active) && (py < v_active);
    exp_r   = pix_act ? px[8:5] : '0;
    exp_g   = pix_act ? py[8:5] : '0;
    exp_b   = pix_act ? pf[5:2] : '0;
    exp_hs  = !(pin_on && (px >= h_active + h_front) && (px < h_active + h_front + h_sync));
    exp_vs  = !(pin_on && (py >= v_active + v_front) && (py < v_active + v_front + v_sync));
  end

  assert property (@(posedge design_clk) disable iff (!checks_on) hs === exp_hs)
    else report_value("hs", 32'($sampled(hs)), 32'($sampled(exp_hs)));
  assert property (@(posedge design_clk) disable iff (!checks_on) vs === exp_vs)
    else report_value("vs", 32'($sampled(vs)), 32'($sampled(exp_vs)));
  assert property (@(posedge design_clk) disable iff (!checks_on) r === exp_r)
    else report_value("r", 32'($sampled(r)), 32'($sampled(exp_r)));
  assert property (@(posedge design_clk) disable iff (!checks_on) g === exp_g)
    else report_value("g", 32'($sampled(g)), 32'($sampled(exp_g)));
  assert property (@(posedge design_clk) disable iff (!checks_on) b === exp_b)
    else report_value("b", 32'($sampled(b)), 32'($sampled(exp_b)));
  assert property (@(posedge design_clk) disable iff (!checks_on) !pin_on |-> leds === '0)
    else report_value("leds", 32'($sampled(leds)), 32'h0);
  assert property (@(posedge design_clk) disable iff (!checks_on)
                   leds[num_btns+1] === hb_exp)
    else report_value("leds[4]", 32'($sampled(leds[num_btns+1])), 32'($sampled(hb_exp)));
  assert property (@(posedge design_clk) disable iff (!checks_on)
                   $fell(hs) |-> core_on && cyc >= hs_first && (cyc - hs_first) % ht == 0)
    else report_text("horizontal sync fell outside its slot in the line");
  assert property (@(posedge design_clk) disable iff (!checks_on)
                   $fell(vs) |-> core_on && cyc >= vs_first && (cyc - vs_first) % frame_len == 0)
    else report_text("vertical sync fell outside its slot in the frame");
  assert property (@(posedge design_clk) disable iff (!checks_on)
                   $rose(hs) |-> hs_run == int'(h_sync))
    else report_text("horizontal sync pulse has the wrong width");
  assert property (@(posedge design_clk) disable iff (!checks_on)
                   $rose(vs) |-> vs_run == int'(v_sync) * ht)
    else report_text("vertical sync pulse has the wrong width");

  initial begin
    repeat (watchdog_cycles) @(posedge design_clk);
    $display("watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int start_errs;
    rst_n     = 1'b0;
    btns      = '0;
    checks_on = 1'b0;
    lfsr      = 16'd19351;
    exp_tgl   = '0;

    start_errs = errors;
    repeat (3) @(negedge design_clk);
    checks_on = 1'b1; // outputs are out of X by now
    repeat (2) @(negedge design_clk);
    rst_n = 1'b1;
    while (hs_falls == 0) @(negedge design_clk);
    finish_test("reset_stretch", start_errs);

    start_errs = errors;
    for (int i = 0; i < num_presses; i++) begin
      press_buttons();
    end
    finish_test("led_buttons", start_errs);

    start_errs = errors;
    while (!(core_on && cyc >= 2 * frame_len + 4)) @(negedge design_clk);
    assert (vs_falls == 2)
      else report_text("two frames did not give two vertical syncs");
    assert (hs_falls == 2 * int'(v_total))
      else report_text("two frames did not give one horizontal sync per line");
    finish_test("video_frames", start_errs);

    $display("summary: %0d tests, %0d failed, %0d errors", tests, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_board_top \
  -f all.f \
  -o sim_board_top

./obj_dir/sim_board_top | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run.sh: testbench reported failure"
  exit 1
fi

echo "run.sh: done"
exit 0

//--- verilog/board_pkg.sv
`default_nettype none

package board_pkg;

  localparam int num_leds  = 5;
  localparam int num_btns  = 3;
  localparam int pin_depth = 4;  // colour bits per channel at the connector

  // core held in reset this many cycles after rst_n releases
  localparam int reset_stretch = 30;
  localparam int reset_cnt_w   = $clog2(reset_stretch + 1);

endpackage

`default_nettype wire

//--- verilog/board_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_top (
  input  logic                           design_clk,
  input  logic                           rst_n,
  input  logic [board_pkg::num_btns-1:0]  btns,
  output logic [board_pkg::num_leds-1:0]  leds,
  output logic [board_pkg::pin_depth-1:0] r,
  output logic [board_pkg::pin_depth-1:0] g,
  output logic [board_pkg::pin_depth-1:0] b,
  output logic                           hs,
  output logic                           vs
);

  import video_pkg::*;
  import board_pkg::*;

  logic       core_rst_n;
  video_pos_t pos;
  logic       frame_start;
  vga_out_t   vga;

  reset_gen i_reset_gen (
    .design_clk (design_clk),
    .rst_n      (rst_n),
    .core_rst_n (core_rst_n)
  );

  vga_timing i_vga_timing (
    .design_clk  (design_clk),
    .core_rst_n  (core_rst_n),
    .pos         (pos),
    .frame_start (frame_start)
  );

  pattern_gen i_pattern_gen (
    .design_clk  (design_clk),
    .core_rst_n  (core_rst_n),
    .pos         (pos),
    .frame_start (frame_start),
    .vga         (vga)
  );

  led_status i_led_status (
    .design_clk  (design_clk),
    .core_rst_n  (core_rst_n),
    .btns        (btns),
    .frame_start (frame_start),
    .leds        (leds)
  );

  // connector only carries the top bits of each channel
  assign r  = vga.r[color_depth-1 -: pin_depth];
  assign g  = vga.g[color_depth-1 -: pin_depth];
  assign b  = vga.b[color_depth-1 -: pin_depth];
  assign hs = vga.hs;
  assign vs = vga.vs;

endmodule

`default_nettype wire

//--- verilog/led_status.sv
`timescale 1ns/1ps
`default_nettype none

module led_status (
  input  logic                          design_clk,
  input  logic                          core_rst_n,
  input  logic [board_pkg::num_btns-1:0] btns,
  input  logic                          frame_start,
  output logic [board_pkg::num_leds-1:0] leds
);

  import board_pkg::*;

  logic [num_btns-1:0] btn_meta;
  logic [num_btns-1:0] btn_sync;
  logic [num_btns-1:0] btn_prev;
  logic [num_btns-1:0] btn_rise;
  logic                frame_d;

  assign btn_rise = btn_sync & ~btn_prev;

  always_ff @(posedge design_clk) begin
    if (!core_rst_n) begin
      btn_meta <= '0;
      btn_sync <= '0;
      btn_prev <= '0;
      frame_d  <= 1'b0;
      leds     <= '0;
    end else begin
      btn_meta <= btns;     // async pins
      btn_sync <= btn_meta;
      btn_prev <= btn_sync;
      frame_d  <= frame_start; // heartbeat lands 2 cycles after frame start
      leds[num_btns-1:0] <= leds[num_btns-1:0] ^ btn_rise;
      leds[num_btns]     <= |btn_sync;  // any button held
      leds[num_btns+1]   <= leds[num_btns+1] ^ frame_d;
    end
  end

endmodule

`default_nettype wire

//--- verilog/pattern_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_gen (
  input  logic                  design_clk,
  input  logic                  core_rst_n,
  input  video_pkg::video_pos_t pos,
  input  logic                  frame_start,
  output video_pkg::vga_out_t   vga
);

  import video_pkg::*;

  logic [color_depth-1:0] frame_cnt;
  logic [color_depth-1:0] r_next;
  logic [color_depth-1:0] g_next;
  logic [color_depth-1:0] b_next;

  always_ff @(posedge design_clk) begin
    if (!core_rst_n) begin
      frame_cnt <= '0;
    end else if (frame_start) begin
      frame_cnt <= frame_cnt + 1'b1;
    end
  end

  // coarse gradients of 8 pixels per step
  always_comb begin
    if (pos.active) begin
      r_next = pos.x[3 +: color_depth];
      g_next = pos.y[3 +: color_depth];
      b_next = frame_cnt; // value before this cycle's increment
    end else begin
      r_next = '0;
      g_next = '0;
      b_next = '0;
    end
  end

  always_ff @(posedge design_clk) begin
    if (!core_rst_n) begin
      vga.hs <= 1'b1;
      vga.vs <= 1'b1;
      vga.r  <= '0;
      vga.g  <= '0;
      vga.b  <= '0;
    end else begin
      vga.hs <= pos.hs; // syncs ride with the colour
      vga.vs <= pos.vs;
      vga.r  <= r_next;
      vga.g  <= g_next;
      vga.b  <= b_next;
    end
  end

endmodule

`default_nettype wire

//--- verilog/reset_gen.sv
`timescale 1ns/1ps
`default_nettype none

module reset_gen (
  input  logic design_clk,
  input  logic rst_n,
  output logic core_rst_n
);

  import board_pkg::*;

  logic [reset_cnt_w-1:0] cnt;

  always_ff @(posedge design_clk) begin
    if (!rst_n) begin
      cnt        <= reset_cnt_w'(reset_stretch);
      core_rst_n <= 1'b0;
    end else begin
      if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
      core_rst_n <= (cnt == '0); // one cycle after count hits zero
    end
  end

endmodule

`default_nettype wire

//--- verilog/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
  input  logic                  design_clk,
  input  logic                  core_rst_n,
  output video_pkg::video_pos_t pos,
  output logic                  frame_start
);

  import video_pkg::*;

  logic [coord_w-1:0] x_next;
  logic [coord_w-1:0] y_next;
  logic               line_end;
  logic               frame_end;
  logic               active_next;
  logic               hs_next;
  logic               vs_next;

  assign line_end  = (pos.x == h_total - 10'd1);
  assign frame_end = (pos.y == v_total - 10'd1);

  // next counter values
  always_comb begin
    x_next = pos.x + 10'd1;
    y_next = pos.y;
    if (line_end) begin
      x_next = '0;
      if (frame_end) begin
        y_next = '0;
      end else begin
        y_next = pos.y + 10'd1;
      end
    end
  end

  // decode from the next counts so every field lands in the same cycle
  always_comb begin
    active_next = (x_next < h_active) && (y_next < v_active);
    hs_next     = !((x_next >= h_active + h_front) &&
                    (x_next <  h_active + h_front + h_sync));
    vs_next     = !((y_next >= v_active + v_front) &&
                    (y_next <  v_active + v_front + v_sync));
  end

  always_ff @(posedge design_clk) begin
    if (!core_rst_n) begin
      pos.x       <= '0;
      pos.y       <= '0;
      pos.active  <= 1'b1; // coherent with x = y = 0
      pos.hs      <= 1'b1;
      pos.vs      <= 1'b1;
      frame_start <= 1'b1;
    end else begin
      pos.x       <= x_next;
      pos.y       <= y_next;
      pos.active  <= active_next;
      pos.hs      <= hs_next;
      pos.vs      <= vs_next;
      frame_start <= (x_next == '0) && (y_next == '0);
    end
  end

endmodule

`default_nettype wire

//--- verilog/video_pkg.sv
`default_nettype none

package video_pkg;

  localparam int coord_w = 10;

  // horizontal timing in pixel clocks
  localparam logic [coord_w-1:0] h_active = 10'd640;
  localparam logic [coord_w-1:0] h_front  = 10'd16;
  localparam logic [coord_w-1:0] h_sync   = 10'd96;
  localparam logic [coord_w-1:0] h_back   = 10'd48;
  localparam logic [coord_w-1:0] h_total  = 10'd800; // sum of the four above

  // vertical timing in lines
  localparam logic [coord_w-1:0] v_active = 10'd480;
  localparam logic [coord_w-1:0] v_front  = 10'd10;
  localparam logic [coord_w-1:0] v_sync   = 10'd2;
  localparam logic [coord_w-1:0] v_back   = 10'd33;
  localparam logic [coord_w-1:0] v_total  = 10'd525;

  localparam int color_depth = 6; // core bits per channel

  typedef struct packed {
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
    logic               active;
    logic               hs;     // active low
    logic               vs;     // active low
  } video_pos_t;

  typedef struct packed {
    logic                   hs;
    logic                   vs;
    logic [color_depth-1:0] r;
    logic [color_depth-1:0] g;
    logic [color_depth-1:0] b;
  } vga_out_t;

endpackage

`default_nettype wire
